// File: include/wmark_settings.svh
// Global settings of the FIFO occupancy monitor
// Data width, channel count, CPU address layout, FIFO depth, sample period

`ifndef WMARK_SETTINGS_SVH
`define WMARK_SETTINGS_SVH

// Width of a level and of a CPU data word
`define WMARK_DATA_W 16

// Monitored channels and the address bits that select one
`define WMARK_NUM_CH 4
`define WMARK_CH_W 2

// Channel field on top of two register bits
`define WMARK_ADDR_W (`WMARK_CH_W + 2)

// Saturation limit of each occupancy count
`define WMARK_FIFO_DEPTH 200

// Cycles between two level samples
`define WMARK_SAMPLE_PERIOD 8

`endif

// File: hdl/wmark_pkg.sv
// Shared types of the FIFO occupancy monitor
// Data word, level sample, CPU request and CPU response

`include "wmark_settings.svh"

package wmark_pkg;

    // One level or CPU data word
    typedef logic [`WMARK_DATA_W-1:0] data_t;

    // Periodic level sample from an occupancy counter
    typedef struct packed {
        logic  valid;
        data_t level;
    } level_sample_t;

    // CPU request, plain strobes without handshake
    typedef struct packed {
        logic                     en;
        logic                     wr;
        logic                     rd;
        logic [`WMARK_ADDR_W-1:0] addr;
        data_t                    wdata;
    } cpu_req_t;

    // CPU response, rdy in the same cycle as the request
    typedef struct packed {
        data_t rdata;
        logic  rdy;
    } cpu_rsp_t;

endpackage

// File: hdl/occupancy_counter.sv
// Occupancy counter of one monitored FIFO
// Saturating fill count from push/pop strobes and periodic level sample

`include "wmark_settings.svh"

module occupancy_counter import wmark_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          push,
    input  logic          pop,
    output level_sample_t sample
);

    localparam int PER_W = $clog2(`WMARK_SAMPLE_PERIOD);
    localparam data_t FIFO_DEPTH = data_t'(`WMARK_FIFO_DEPTH);
    localparam logic [PER_W-1:0] LAST_TICK = PER_W'(`WMARK_SAMPLE_PERIOD - 1);

    data_t            level;
    logic [PER_W-1:0] tick;
    logic             sample_valid;
    data_t            sample_level;

    //////////////////////////////////////////////////////////////////////
    // Fill level

    // Push with pop cancels, ends of range hold
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            level <= '0;
        end
        else if (push && !pop && (level < FIFO_DEPTH))
        begin
            level <= level + 1'b1;
        end
        else if (pop && !push && (level != '0))
        begin
            level <= level - 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Sample interval

    // Free running, one valid pulse per period
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tick         <= '0;
            sample_valid <= 1'b0;
        end
        else
        begin
            sample_valid <= (tick == LAST_TICK);
            tick         <= (tick == LAST_TICK) ? '0 : tick + 1'b1;
        end
    end

    // Level captured together with the valid pulse
    always_ff @(posedge clk)
    begin
        if (tick == LAST_TICK)
        begin
            sample_level <= level;
        end
    end

    assign sample = '{valid: sample_valid, level: sample_level};

endmodule

// File: hdl/watermark_cell.sv
// Watermark cell, one low or high watermark register
// track_min selects lowest (1) or highest (0) level tracking
// CPU write reloads the register and wins over an update

`include "wmark_settings.svh"

module watermark_cell import wmark_pkg::*;
#(
    parameter bit track_min = 1'b1
)
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     upd,
    input  logic [`WMARK_DATA_W-1:0] level,
    input  logic                     wr_en,
    input  logic [`WMARK_DATA_W-1:0] wdata,
    output logic [`WMARK_DATA_W-1:0] value
);

    // Min starts at all ones, max at zero
    localparam data_t RST_VALUE = track_min ? {`WMARK_DATA_W{1'b1}} : '0;

    data_t stored;
    logic  beyond;

    //////////////////////////////////////////////////////////////////////
    // Compare

    // New level past the stored mark in the tracked direction
    always_comb
    begin
        if (track_min)
        begin
            beyond = (level < stored);
        end
        else
        begin
            beyond = (level > stored);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Watermark register

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            stored <= RST_VALUE;
        end
        else if (wr_en)
        begin
            // CPU reload, also used to clear
            stored <= wdata;
        end
        else if (upd && beyond)
        begin
            stored <= level;
        end
    end

    assign value = stored;

endmodule

// File: hdl/level_watermark.sv
// Level watermark block of one channel
// Current-level register, low and high watermark cells
// Register decode, write gating and read-data merge

`include "wmark_settings.svh"

module level_watermark import wmark_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  level_sample_t            sample,
    input  logic                     ch_en,
    input  cpu_req_t                 cpu_req,
    output logic [`WMARK_DATA_W-1:0] rdata
);

    // Register offsets inside a channel, offset 3 reads zero
    localparam logic [1:0] REG_LOW  = 2'd0;
    localparam logic [1:0] REG_HIGH = 2'd1;
    localparam logic [1:0] REG_CUR  = 2'd2;

    data_t cur_level;
    logic  upd_d;
    logic  low_sel;
    logic  high_sel;
    logic  cur_sel;
    data_t low_value;
    data_t high_value;

    //////////////////////////////////////////////////////////////////////
    // Current level

    // Loads on a valid sample
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cur_level <= '0;
        end
        else if (sample.valid)
        begin
            cur_level <= sample.level;
        end
    end

    // Cells compare one edge after the current register loads
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            upd_d <= 1'b0;
        end
        else
        begin
            upd_d <= sample.valid;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Register decode

    assign low_sel  = ch_en && (cpu_req.addr[1:0] == REG_LOW);
    assign high_sel = ch_en && (cpu_req.addr[1:0] == REG_HIGH);
    assign cur_sel  = ch_en && (cpu_req.addr[1:0] == REG_CUR);

    //////////////////////////////////////////////////////////////////////
    // Watermark cells

    // Lowest level
    watermark_cell #(.track_min(1'b1)) i_low_cell
    (
        .clk   (clk),
        .rst   (rst),
        .upd   (upd_d),
        .level (cur_level),
        .wr_en (low_sel && cpu_req.wr),
        .wdata (cpu_req.wdata),
        .value (low_value)
    );

    // Highest level
    watermark_cell #(.track_min(1'b0)) i_high_cell
    (
        .clk   (clk),
        .rst   (rst),
        .upd   (upd_d),
        .level (cur_level),
        .wr_en (high_sel && cpu_req.wr),
        .wdata (cpu_req.wdata),
        .value (high_value)
    );

    // Unselected registers contribute zero
    assign rdata = (cur_sel  ? cur_level  : '0)
                 | (low_sel  ? low_value  : '0)
                 | (high_sel ? high_value : '0);

endmodule

// File: hdl/cpu_channel_decode.sv
// CPU channel decode
// One-hot channel enables from the address, read-data merge, ready

`include "wmark_settings.svh"

module cpu_channel_decode import wmark_pkg::*;
(
    input  cpu_req_t                     cpu_req,
    input  data_t [`WMARK_NUM_CH-1:0]    ch_rdata,
    output logic  [`WMARK_NUM_CH-1:0]    ch_en,
    output cpu_rsp_t                     cpu_rsp
);

    logic [`WMARK_CH_W-1:0] ch_field;

    // Channel field above the two register bits
    assign ch_field = cpu_req.addr[`WMARK_ADDR_W-1:2];

    //////////////////////////////////////////////////////////////////////
    // Channel enables

    always_comb
    begin
        for (int ch = 0; ch < `WMARK_NUM_CH; ch++)
        begin
            ch_en[ch] = cpu_req.en && (ch_field == `WMARK_CH_W'(ch));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Response

    // Unselected channels already return zero
    always_comb
    begin
        data_t merged;
        merged = '0;
        for (int ch = 0; ch < `WMARK_NUM_CH; ch++)
        begin
            merged = merged | ch_rdata[ch];
        end
        cpu_rsp.rdata = merged;
    end

    // Always ready, same cycle as the strobe
    assign cpu_rsp.rdy = cpu_req.en && (cpu_req.wr || cpu_req.rd);

endmodule

// File: hdl/wmark_top.sv
// FIFO occupancy monitor top level
// Per channel occupancy counter and level watermark block
// CPU channel decode shared by all channels

`include "wmark_settings.svh"

module wmark_top import wmark_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`WMARK_NUM_CH-1:0] push,
    input  logic [`WMARK_NUM_CH-1:0] pop,
    input  cpu_req_t                 cpu_req,
    output cpu_rsp_t                 cpu_rsp
);

    level_sample_t [`WMARK_NUM_CH-1:0] ch_sample;
    data_t         [`WMARK_NUM_CH-1:0] ch_rdata;
    logic          [`WMARK_NUM_CH-1:0] ch_en;

    //////////////////////////////////////////////////////////////////////
    // Channels

    for (genvar ch = 0; ch < `WMARK_NUM_CH; ch++)
    begin : g_ch
        // Fill count and periodic sample
        occupancy_counter i_occupancy_counter
        (
            .clk    (clk),
            .rst    (rst),
            .push   (push[ch]),
            .pop    (pop[ch]),
            .sample (ch_sample[ch])
        );

        // Current, low and high level registers
        level_watermark i_level_watermark
        (
            .clk     (clk),
            .rst     (rst),
            .sample  (ch_sample[ch]),
            .ch_en   (ch_en[ch]),
            .cpu_req (cpu_req),
            .rdata   (ch_rdata[ch])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // CPU decode

    cpu_channel_decode i_cpu_channel_decode
    (
        .cpu_req  (cpu_req),
        .ch_rdata (ch_rdata),
        .ch_en    (ch_en),
        .cpu_rsp  (cpu_rsp)
    );

endmodule

// File: bench/wmark_tb.sv
// Directed testbench of the FIFO occupancy monitor
// Clock, reset, per-channel level model, CPU read/write tasks
// Tests for reset, fill, drain, saturation and channel isolation

`include "wmark_settings.svh"

module wmark_tb import wmark_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CH = `WMARK_NUM_CH;
    localparam int DEPTH = `WMARK_FIFO_DEPTH;
    localparam int SETTLE_CYCLES = 2 * `WMARK_SAMPLE_PERIOD + 4;
    localparam int ALL_ONES = (1 << `WMARK_DATA_W) - 1;
    // Register offsets inside a channel
    localparam int REG_LOW = 0;
    localparam int REG_HIGH = 1;
    localparam int REG_CUR = 2;
    localparam int REG_NONE = 3;

    logic                clk;
    logic                rst;
    logic [NUM_CH-1:0]   push;
    logic [NUM_CH-1:0]   pop;
    cpu_req_t            cpu_req;
    cpu_rsp_t            cpu_rsp;

    // Expected register contents per channel
    int     level_model[NUM_CH];
    int     low_model[NUM_CH];
    int     high_model[NUM_CH];
    integer seed;

    wmark_top i_wmark_top
    (
        .clk     (clk),
        .rst     (rst),
        .push    (push),
        .pop     (pop),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Check and CPU tasks

    task automatic check(input int got, input int expected, input string what);
        if (got != expected)
        begin
            $display("[ERROR] %0t: %s, got %0d expected %0d", $time, what, got, expected);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // One read cycle, rdata sampled while the request is held
    task automatic cpu_read(input int ch, input int r, output int rdata);
        @(negedge clk);
        cpu_req       = '0;
        cpu_req.en    = 1'b1;
        cpu_req.rd    = 1'b1;
        cpu_req.addr  = `WMARK_ADDR_W'(ch * 4 + r);
        #2;
        check(cpu_rsp.rdy, 1, "rdy during read");
        rdata = cpu_rsp.rdata;
    endtask

    // Write lands at the next rising edge
    task automatic cpu_write(input int ch, input int r, input int wdata);
        @(negedge clk);
        cpu_req       = '0;
        cpu_req.en    = 1'b1;
        cpu_req.wr    = 1'b1;
        cpu_req.addr  = `WMARK_ADDR_W'(ch * 4 + r);
        cpu_req.wdata = data_t'(wdata);
        #2;
        check(cpu_rsp.rdy, 1, "rdy during write");
        @(negedge clk);
        cpu_req = '0;
    endtask

    task automatic expect_reg(input int ch, input int r, input int expected);
        int rdata;
        cpu_read(ch, r, rdata);
        check(rdata, expected, $sformatf("channel %0d register %0d", ch, r));
    endtask

    // All four registers of one channel against the model
    task automatic check_channel(input int ch);
        expect_reg(ch, REG_LOW, low_model[ch]);
        expect_reg(ch, REG_HIGH, high_model[ch]);
        expect_reg(ch, REG_CUR, level_model[ch]);
        expect_reg(ch, REG_NONE, 0);
        @(negedge clk);
        cpu_req = '0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // FIFO strobes and level model

    // Saturates at the FIFO depth
    task automatic push_n(input int ch, input int n);
        for (int i = 0; i < n; i++)
        begin
            @(negedge clk);
            push[ch] = 1'b1;
            if (level_model[ch] < DEPTH)
                level_model[ch]++;
        end
        @(negedge clk);
        push[ch] = 1'b0;
    endtask

    // Pop at zero is ignored
    task automatic pop_n(input int ch, input int n);
        for (int i = 0; i < n; i++)
        begin
            @(negedge clk);
            pop[ch] = 1'b1;
            if (level_model[ch] > 0)
                level_model[ch]--;
        end
        @(negedge clk);
        pop[ch] = 1'b0;
    endtask

    // Two sample periods plus pipeline, then watermarks follow the level
    task automatic settle();
        int  cycles;
        time start;
        cycles = 0;
        start  = $time;
        while (cycles < SETTLE_CYCLES)
        begin
            @(posedge clk);
            cycles++;
            if ($time - start > 20 * SETTLE_CYCLES)
            begin
                $display("Timeout: clock stalled while waiting for samples to settle");
                $display("Regression failed");
                $fatal(1);
            end
        end
        for (int ch = 0; ch < NUM_CH; ch++)
        begin
            if (level_model[ch] < low_model[ch])
                low_model[ch] = level_model[ch];
            if (level_model[ch] > high_model[ch])
                high_model[ch] = level_model[ch];
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests

    task automatic reset_state();
        // Low marks first, the first sample arrives one period after reset
        for (int ch = 0; ch < NUM_CH; ch++)
            expect_reg(ch, REG_LOW, ALL_ONES);
        for (int ch = 0; ch < NUM_CH; ch++)
        begin
            expect_reg(ch, REG_HIGH, 0);
            expect_reg(ch, REG_CUR, 0);
        end
        // Strobe without en gets no ready
        @(negedge clk);
        cpu_req    = '0;
        cpu_req.rd = 1'b1;
        #2;
        check(cpu_rsp.rdy, 0, "rdy with en low");
        @(negedge clk);
        cpu_req = '0;
    endtask

    task automatic fill_levels();
        push_n(0, 20 + ($unsigned($random(seed)) % 60));
        settle();
        check_channel(0);
        // Samples at level zero before the fill
        expect_reg(0, REG_LOW, 0);
    endtask

    task automatic drain_after_reload();
        cpu_write(0, REG_LOW, ALL_ONES);
        low_model[0] = ALL_ONES;
        pop_n(0, 5 + ($unsigned($random(seed)) % 15));
        settle();
        check_channel(0);
    endtask

    task automatic saturate_and_underflow();
        push_n(1, DEPTH + 10);
        settle();
        expect_reg(1, REG_HIGH, DEPTH);
        check_channel(1);
        // Extra pops at zero must not wrap
        pop_n(1, DEPTH + 5);
        settle();
        check_channel(1);
    endtask

    task automatic channel_isolation();
        push_n(2, 10 + ($unsigned($random(seed)) % 40));
        settle();
        for (int ch = 0; ch < NUM_CH; ch++)
            check_channel(ch);
        // Current level and offset 3 are read only
        cpu_write(2, REG_CUR, 'h1234);
        cpu_write(2, REG_NONE, 'h5678);
        check_channel(2);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence

    initial
    begin
        clk     = 1'b0;
        rst     = 1'b1;
        push    = '0;
        pop     = '0;
        cpu_req = '0;
        seed    = 43;
        for (int ch = 0; ch < NUM_CH; ch++)
        begin
            level_model[ch] = 0;
            low_model[ch]   = ALL_ONES;
            high_model[ch]  = 0;
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;
        reset_state();
        settle();
        fill_levels();
        drain_after_reload();
        saturate_and_underflow();
        channel_isolation();
        $display("Regression passed");
        $finish;
    end

endmodule

// File: wmark.f
+incdir+include
hdl/wmark_pkg.sv
hdl/occupancy_counter.sv
hdl/watermark_cell.sv
hdl/level_watermark.sv
hdl/cpu_channel_decode.sv
hdl/wmark_top.sv
bench/wmark_tb.sv
